// ==== design/pkt_check_pkg.sv ====
package pkt_check_pkg;

	//////////////////////////////////////////////////
	// Widths and register map
	//////////////////////////////////////////////////

	// Packet memory word address
	localparam int MEM_AW = 14;
	// AXI4-Lite byte address
	localparam int AXIL_AW = 8;

	// Register byte offsets
	localparam logic [AXIL_AW-1:0] CSR_CTRL     = 8'h00;
	localparam logic [AXIL_AW-1:0] CSR_HDR_ADDR = 8'h04;
	localparam logic [AXIL_AW-1:0] CSR_STATUS   = 8'h08;

	// AXI response code
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	// CRC-8, zero init, MSB first, no final xor
	localparam logic [7:0] CRC_POLY = 8'h07;

	//////////////////////////////////////////////////
	// Packet header and results
	//////////////////////////////////////////////////

	// Header word as stored in packet memory
	typedef struct packed {
		logic [15:0] unused;
		logic [2:0]  sop;
		logic        parity;
		logic [3:0]  pkt_type;
		logic [3:0]  byte_cnt;
		logic [3:0]  ecc;
	} hdr_t;

	typedef enum logic [1:0] {
		ECC_CLEAN  = 2'd0,
		ECC_CORR   = 2'd1,
		ECC_UNCORR = 2'd2
	} ecc_class_t;

	// Byte count is the repaired value
	typedef struct packed {
		logic       ecc_corr;
		logic       ecc_uncorr;
		logic       crc_err;
		logic [3:0] byte_cnt;
		logic [3:0] pkt_type;
	} pkt_result_t;

	//////////////////////////////////////////////////
	// Bus channels
	//////////////////////////////////////////////////

	// Master to slave
	typedef struct packed {
		logic               awvalid;
		logic [AXIL_AW-1:0] awaddr;
		logic               wvalid;
		logic [31:0]        wdata;
		logic [3:0]         wstrb;
		logic               bready;
		logic               arvalid;
		logic [AXIL_AW-1:0] araddr;
		logic               rready;
	} axil_req_t;

	// Slave to master
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	// Packet memory read port
	typedef struct packed {
		logic              en;
		logic [MEM_AW-1:0] addr;
	} mem_req_t;

endpackage

// ==== design/crc8_byte.sv ====
module crc8_byte import pkt_check_pkg::*; (
	input  logic [7:0] crc_i,
	input  logic [7:0] data_i,
	output logic [7:0] crc_o
);

	logic [7:0] crc_acc;

	// One byte, MSB first
	always_comb begin
		// Byte enters at the top of the register
		crc_acc = crc_i ^ data_i;
		for (int i = 0; i < 8; i++) begin
			if (crc_acc[7])
				crc_acc = {crc_acc[6:0], 1'b0} ^ CRC_POLY;
			else
				crc_acc = {crc_acc[6:0], 1'b0};
		end
		crc_o = crc_acc;
	end

endmodule

// ==== design/hdr_ecc.sv ====
module hdr_ecc import pkt_check_pkg::*; (
	input  hdr_t       hdr_i,
	output ecc_class_t ecc_class_o,
	output logic [3:0] byte_cnt_o,
	output logic [3:0] pkt_type_o
);

	// Protected data is {pkt_type, byte_cnt}
	logic [7:0] data;
	logic [3:0] code;
	logic [3:0] syndrome;
	logic parity_err;
	logic [7:0] flip;
	ecc_class_t ecc_class;

	assign data = {hdr_i.pkt_type, hdr_i.byte_cnt};

	// Recomputed Hamming code bits
	assign code[0] = data[0] ^ data[1] ^ data[3] ^ data[4] ^ data[6];
	assign code[1] = data[0] ^ data[2] ^ data[3] ^ data[5] ^ data[6];
	assign code[2] = data[1] ^ data[2] ^ data[3] ^ data[7];
	assign code[3] = data[4] ^ data[5] ^ data[6] ^ data[7];

	assign syndrome = hdr_i.ecc ^ code;
	// Stored parity against parity of data bits
	assign parity_err = (^data) ^ hdr_i.parity;

	// Odd error count with a syndrome means one bit flipped
	always_comb begin
		if (syndrome == 4'd0)
			ecc_class = ECC_CLEAN;
		else if (parity_err)
			ecc_class = ECC_CORR;
		else
			ecc_class = ECC_UNCORR;
	end

	// Syndrome to data bit position
	always_comb begin
		case (syndrome)
			4'd3:  flip = 8'h01;
			4'd5:  flip = 8'h02;
			4'd6:  flip = 8'h04;
			4'd7:  flip = 8'h08;
			4'd9:  flip = 8'h10;
			4'd10: flip = 8'h20;
			4'd11: flip = 8'h40;
			4'd12: flip = 8'h80;
			// Code bit position, data left alone
			default: flip = 8'h00;
		endcase
	end

	assign ecc_class_o = ecc_class;
	assign {pkt_type_o, byte_cnt_o} = (ecc_class == ECC_CORR) ? (data ^ flip) : data;

endmodule

// ==== design/pkt_walker.sv ====
module pkt_walker import pkt_check_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              start_i,
	input  logic [MEM_AW-1:0] hdr_addr_i,
	output mem_req_t          mem_req_o,
	input  logic [31:0]       mem_data_i,
	output logic              busy_o,
	output logic              done_o,
	output pkt_result_t       result_o
);

	typedef enum logic [1:0] {IDLE, HEADER, PAYLOAD, COMPARE} state_t;

	state_t state_q, state_d;
	// Next word address to issue
	logic [MEM_AW-1:0] addr_q, addr_d;
	// Payload words still to arrive
	logic [3:0] cnt_q, cnt_d;
	logic [7:0] crc_q, crc_d;
	logic [7:0] crc_ext_q, crc_ext_d;
	logic [7:0] crc_step;
	logic [3:0] byte_cnt_q, byte_cnt_d;
	logic [3:0] pkt_type_q, pkt_type_d;
	logic corr_q, corr_d;
	logic uncorr_q, uncorr_d;

	// Header decode
	hdr_t hdr_word;
	ecc_class_t ecc_class;
	logic [3:0] fix_byte_cnt;
	logic [3:0] fix_pkt_type;

	//////////////////////////////////////////////////
	// Checkers
	//////////////////////////////////////////////////

	assign hdr_word = mem_data_i;

	hdr_ecc i_hdr_ecc (
		.hdr_i       (hdr_word),
		.ecc_class_o (ecc_class),
		.byte_cnt_o  (fix_byte_cnt),
		.pkt_type_o  (fix_pkt_type)
	);

	// Payload byte sits in the low byte of each word
	crc8_byte i_crc8_byte (
		.crc_i  (crc_q),
		.data_i (mem_data_i[7:0]),
		.crc_o  (crc_step)
	);

	//////////////////////////////////////////////////
	// State and datapath registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	always_ff @(posedge clk) begin
		addr_q     <= addr_d;
		cnt_q      <= cnt_d;
		crc_q      <= crc_d;
		crc_ext_q  <= crc_ext_d;
		byte_cnt_q <= byte_cnt_d;
		pkt_type_q <= pkt_type_d;
		corr_q     <= corr_d;
		uncorr_q   <= uncorr_d;
	end

	//////////////////////////////////////////////////
	// Next state and read issue
	//////////////////////////////////////////////////

	// Data for the word issued last cycle is on mem_data_i now
	always_comb begin
		state_d        = state_q;
		addr_d         = addr_q;
		cnt_d          = cnt_q;
		crc_d          = crc_q;
		crc_ext_d      = crc_ext_q;
		byte_cnt_d     = byte_cnt_q;
		pkt_type_d     = pkt_type_q;
		corr_d         = corr_q;
		uncorr_d       = uncorr_q;
		mem_req_o.en   = 1'b0;
		mem_req_o.addr = addr_q;
		case (state_q)
			IDLE: begin
				// Header read goes out with the start pulse
				if (start_i) begin
					mem_req_o.en   = 1'b1;
					mem_req_o.addr = hdr_addr_i;
					addr_d         = hdr_addr_i + 1'b1;
					state_d        = HEADER;
				end
			end
			HEADER: begin
				byte_cnt_d = fix_byte_cnt;
				pkt_type_d = fix_pkt_type;
				corr_d     = (ecc_class == ECC_CORR);
				uncorr_d   = (ecc_class == ECC_UNCORR);
				cnt_d      = fix_byte_cnt;
				crc_d      = 8'd0;
				// Bad header, skip payload
				if (ecc_class == ECC_UNCORR) begin
					state_d = COMPARE;
				end else begin
					mem_req_o.en = 1'b1;
					addr_d       = addr_q + 1'b1;
					state_d      = PAYLOAD;
				end
			end
			PAYLOAD: begin
				if (cnt_q != 4'd0) begin
					crc_d        = crc_step;
					cnt_d        = cnt_q - 1'b1;
					// Last issue here is the CRC word
					mem_req_o.en = 1'b1;
					addr_d       = addr_q + 1'b1;
				end else begin
					// Stored CRC byte
					crc_ext_d = mem_data_i[7:0];
					state_d   = COMPARE;
				end
			end
			COMPARE: begin
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Status and result
	//////////////////////////////////////////////////

	// Busy already in the cycle the start arrives
	assign busy_o = start_i || (state_q != IDLE);
	assign done_o = (state_q == COMPARE);

	assign result_o.ecc_corr   = corr_q;
	assign result_o.ecc_uncorr = uncorr_q;
	// No CRC verdict after an uncorrectable header
	assign result_o.crc_err    = !uncorr_q && (crc_q != crc_ext_q);
	assign result_o.byte_cnt   = byte_cnt_q;
	assign result_o.pkt_type   = pkt_type_q;

endmodule

// ==== design/axil_csr.sv ====
module axil_csr import pkt_check_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  axil_req_t         axil_req_i,
	output axil_rsp_t         axil_rsp_o,
	input  logic              busy_i,
	input  logic              done_i,
	input  pkt_result_t       result_i,
	output logic              start_o,
	output logic [MEM_AW-1:0] hdr_addr_o,
	output logic              irq_o
);

	// Channel handshake state
	logic awready_q;
	logic bvalid_q;
	logic arready_q;
	logic rvalid_q;
	logic [31:0] rdata_q;
	logic [31:0] rdata_mux;
	logic wr_hs;
	logic rd_hs;

	// Register file
	logic [MEM_AW-1:0] hdr_addr_q;
	logic start_q;
	logic done_q;
	pkt_result_t result_q;

	// Write decode
	logic start_req;
	logic done_clr;

	//////////////////////////////////////////////////
	// Write channel
	//////////////////////////////////////////////////

	// Address and data are taken together in one beat
	assign wr_hs = awready_q && axil_req_i.awvalid && axil_req_i.wvalid;

	always_ff @(posedge clk) begin
		if (reset) begin
			awready_q <= 1'b0;
			bvalid_q  <= 1'b0;
		end else begin
			// One-cycle ready, never while a response is pending
			awready_q <= !awready_q && !bvalid_q &&
				axil_req_i.awvalid && axil_req_i.wvalid;
			if (wr_hs)
				bvalid_q <= 1'b1;
			else if (axil_req_i.bready)
				bvalid_q <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Read channel
	//////////////////////////////////////////////////

	assign rd_hs = arready_q && axil_req_i.arvalid;

	always_ff @(posedge clk) begin
		if (reset) begin
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
		end else begin
			arready_q <= !arready_q && !rvalid_q && axil_req_i.arvalid;
			if (rd_hs)
				rvalid_q <= 1'b1;
			else if (axil_req_i.rready)
				rvalid_q <= 1'b0;
		end
	end

	// Read data only loads on accept, so it holds under back-pressure
	always_ff @(posedge clk) begin
		if (rd_hs)
			rdata_q <= rdata_mux;
	end

	// Unmapped offsets read as zero
	always_comb begin
		case (axil_req_i.araddr)
			CSR_HDR_ADDR: rdata_mux = {{(32 - MEM_AW){1'b0}}, hdr_addr_q};
			CSR_STATUS: rdata_mux = {15'd0, busy_i, 4'd0,
				result_q.pkt_type, result_q.byte_cnt,
				result_q.crc_err, result_q.ecc_uncorr, result_q.ecc_corr, done_q};
			default: rdata_mux = 32'd0;
		endcase
	end

	//////////////////////////////////////////////////
	// Register writes
	//////////////////////////////////////////////////

	// Start only when the walker is free
	assign start_req = wr_hs && (axil_req_i.awaddr == CSR_CTRL) &&
		axil_req_i.wstrb[0] && axil_req_i.wdata[0] && !busy_i;

	// W1C on status bit 0, or implicit on a new start
	assign done_clr = start_req || (wr_hs && (axil_req_i.awaddr == CSR_STATUS) &&
		axil_req_i.wstrb[0] && axil_req_i.wdata[0]);

	always_ff @(posedge clk) begin
		if (reset) begin
			hdr_addr_q <= '0;
			start_q    <= 1'b0;
			done_q     <= 1'b0;
			result_q   <= '0;
		end else begin
			start_q <= start_req;
			// Header address, byte lanes honoured
			if (wr_hs && (axil_req_i.awaddr == CSR_HDR_ADDR)) begin
				if (axil_req_i.wstrb[0])
					hdr_addr_q[7:0] <= axil_req_i.wdata[7:0];
				if (axil_req_i.wstrb[1])
					hdr_addr_q[MEM_AW-1:8] <= axil_req_i.wdata[MEM_AW-1:8];
			end
			// Completion wins over a clear in the same cycle
			if (done_i) begin
				done_q   <= 1'b1;
				result_q <= result_i;
			end else if (done_clr) begin
				done_q <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	assign axil_rsp_o.awready = awready_q;
	assign axil_rsp_o.wready  = awready_q;
	assign axil_rsp_o.bvalid  = bvalid_q;
	assign axil_rsp_o.bresp   = AXI_RESP_OKAY;
	assign axil_rsp_o.arready = arready_q;
	assign axil_rsp_o.rvalid  = rvalid_q;
	assign axil_rsp_o.rdata   = rdata_q;
	assign axil_rsp_o.rresp   = AXI_RESP_OKAY;

	assign start_o    = start_q;
	assign hdr_addr_o = hdr_addr_q;
	// Interrupt is the sticky done flag
	assign irq_o      = done_q;

endmodule

// ==== design/pkt_check_top.sv ====
module pkt_check_top import pkt_check_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  axil_req_t   axil_req_i,
	output axil_rsp_t   axil_rsp_o,
	output mem_req_t    mem_req_o,
	input  logic [31:0] mem_data_i,
	output logic        irq_o
);

	// Register block to walker
	logic start;
	logic [MEM_AW-1:0] hdr_addr;
	// Walker back to register block
	logic busy;
	logic done;
	pkt_result_t result;

	//////////////////////////////////////////////////
	// Register front end
	//////////////////////////////////////////////////

	axil_csr i_axil_csr (
		.clk        (clk),
		.reset      (reset),
		.axil_req_i (axil_req_i),
		.axil_rsp_o (axil_rsp_o),
		.busy_i     (busy),
		.done_i     (done),
		.result_i   (result),
		.start_o    (start),
		.hdr_addr_o (hdr_addr),
		.irq_o      (irq_o)
	);

	//////////////////////////////////////////////////
	// Packet walk and check
	//////////////////////////////////////////////////

	pkt_walker i_pkt_walker (
		.clk        (clk),
		.reset      (reset),
		.start_i    (start),
		.hdr_addr_i (hdr_addr),
		.mem_req_o  (mem_req_o),
		.mem_data_i (mem_data_i),
		.busy_o     (busy),
		.done_o     (done),
		.result_o   (result)
	);

endmodule

// ==== bench/tb_pkt_check_sva.sv ====
module tb_pkt_check_sva import pkt_check_pkg::*; (
	input logic      clk,
	input logic      reset,
	input axil_req_t axil_req_i,
	input axil_rsp_t axil_rsp_i,
	input mem_req_t  mem_req_i,
	input logic      busy_i,
	input logic      done_i,
	input logic      irq_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// Interrupt and both responses cleared by reset
	a_quiet_after_reset: assert property (@(posedge clk)
		reset |=> (!irq_i && !axil_rsp_i.bvalid && !axil_rsp_i.rvalid))
		else $error("irq or AXI response valid high after reset");

	// Write response waits for bready
	a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		(axil_rsp_i.bvalid && !axil_req_i.bready) |=> axil_rsp_i.bvalid)
		else $error("bvalid dropped before bready");

	// Read response and its data wait for rready
	a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
		(axil_rsp_i.rvalid && !axil_req_i.rready) |=>
		(axil_rsp_i.rvalid && $stable(axil_rsp_i.rdata)))
		else $error("rvalid or rdata changed before rready");

	// No memory traffic outside a walk
	a_mem_quiet: assert property (@(posedge clk) disable iff (reset)
		(!busy_i || done_i) |-> !mem_req_i.en)
		else $error("memory read issued while idle or done");

endmodule

bind pkt_check_top tb_pkt_check_sva i_sva (
	.clk        (clk),
	.reset      (reset),
	.axil_req_i (axil_req_i),
	.axil_rsp_i (axil_rsp_o),
	.mem_req_i  (mem_req_o),
	.busy_i     (busy),
	.done_i     (done),
	.irq_i      (irq_o)
);

// ==== bench/tb_pkt_check.sv ====
module tb_pkt_check import pkt_check_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_WORDS = 1 << MEM_AW;
	// Offset past the last register
	localparam logic [AXIL_AW-1:0] CSR_UNMAPPED = 8'h0C;

	logic clk;
	logic reset;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	mem_req_t mem_req;
	mem_req_t mem_req_q;
	logic [31:0] mem_data;
	logic irq;

	// Packet memory and the packet under construction
	logic [31:0] mem [0:MEM_WORDS-1];
	logic [MEM_AW-1:0] pkt_base;
	logic [7:0] pay [0:15];
	int pay_len;
	logic [7:0] crc_byte;
	hdr_t hdr;
	hdr_t bad;
	pkt_result_t exp_res;
	int n_checks;

	pkt_check_top i_dut (
		.clk        (clk),
		.reset      (reset),
		.axil_req_i (axil_req),
		.axil_rsp_o (axil_rsp),
		.mem_req_o  (mem_req),
		.mem_data_i (mem_data),
		.irq_o      (irq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////

	// Request taken at the rising edge, word driven at the falling edge
	always @(posedge clk) begin
		if (reset)
			mem_req_q <= '0;
		else
			mem_req_q <= mem_req;
	end

	always @(negedge clk) begin
		if (mem_req_q.en)
			mem_data = mem[mem_req_q.addr];
	end

	task automatic fill_memory();
		logic [MEM_AW-1:0] a;
		for (int i = 0; i < MEM_WORDS; i++) begin
			a = i[MEM_AW-1:0];
			// Every address bit shows up in the word
			mem[a] = {2'b10, a, ~a[7:0], a[MEM_AW-1:6]};
		end
	endtask

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	task automatic stop_run();
		$display("sim failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0d ns while waiting for %s", $time, what);
		stop_run();
	endtask

	task automatic check_result(input string name, input pkt_result_t got,
			input pkt_result_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_status_bit(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			$display("Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_rdata(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	//////////////////////////////////////////////////
	// AXI4-Lite master
	//////////////////////////////////////////////////

	task automatic axil_write(input logic [AXIL_AW-1:0] addr, input logic [31:0] data);
		int n;
		@(negedge clk);
		axil_req.awvalid = 1'b1;
		axil_req.awaddr  = addr;
		axil_req.wvalid  = 1'b1;
		axil_req.wdata   = data;
		axil_req.wstrb   = 4'hF;
		n = 0;
		@(negedge clk);
		while (!axil_rsp.awready) begin
			n++;
			if (n > 20)
				report_timeout("AXI write address and data accept");
			@(negedge clk);
		end
		// Data channel is accepted in the same beat as the address
		check_status_bit("wready", axil_rsp.wready, 1'b1);
		// Handshake lands on the next rising edge
		@(negedge clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		n = 0;
		while (!axil_rsp.bvalid) begin
			n++;
			if (n > 20)
				report_timeout("AXI write response");
			@(negedge clk);
		end
		check_resp("bresp", axil_rsp.bresp, AXI_RESP_OKAY);
		axil_req.bready = 1'b1;
		@(negedge clk);
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [AXIL_AW-1:0] addr, output logic [31:0] data);
		int n;
		int stall;
		logic [31:0] held;
		@(negedge clk);
		axil_req.arvalid = 1'b1;
		axil_req.araddr  = addr;
		n = 0;
		@(negedge clk);
		while (!axil_rsp.arready) begin
			n++;
			if (n > 20)
				report_timeout("AXI read address accept");
			@(negedge clk);
		end
		@(negedge clk);
		axil_req.arvalid = 1'b0;
		n = 0;
		while (!axil_rsp.rvalid) begin
			n++;
			if (n > 20)
				report_timeout("AXI read data");
			@(negedge clk);
		end
		// Random back-pressure while the data must hold
		held = axil_rsp.rdata;
		stall = $urandom_range(4, 0);
		repeat (stall) begin
			@(negedge clk);
			check_status_bit("rvalid", axil_rsp.rvalid, 1'b1);
			check_rdata("rdata under back-pressure", axil_rsp.rdata, held);
		end
		check_resp("rresp", axil_rsp.rresp, AXI_RESP_OKAY);
		data = axil_rsp.rdata;
		axil_req.rready = 1'b1;
		@(negedge clk);
		axil_req.rready = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Reference model and packets
	//////////////////////////////////////////////////

	// Hamming code over {pkt_type, byte_cnt}
	function automatic logic [3:0] ham_code(input logic [7:0] d);
		logic [3:0] c;
		c[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6];
		c[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6];
		c[2] = d[1] ^ d[2] ^ d[3] ^ d[7];
		c[3] = d[4] ^ d[5] ^ d[6] ^ d[7];
		return c;
	endfunction

	// Bit-serial CRC-8 in feedback form
	function automatic logic [7:0] crc_model(input int n);
		logic [7:0] crc;
		logic [7:0] byte_v;
		logic fb;
		crc = 8'd0;
		for (int i = 0; i < n; i++) begin
			byte_v = pay[i[3:0]];
			for (int b = 0; b < 8; b++) begin
				fb = crc[7] ^ byte_v[7];
				crc = {crc[6:0], 1'b0};
				if (fb)
					crc = crc ^ CRC_POLY;
				byte_v = {byte_v[6:0], 1'b0};
			end
		end
		return crc;
	endfunction

	// Clean header with junk in sop and the unused bits
	function automatic hdr_t make_header(input logic [3:0] cnt, input logic [3:0] typ);
		hdr_t h;
		logic [31:0] rnd;
		rnd = $urandom;
		h.unused   = rnd[15:0];
		h.sop      = rnd[18:16];
		h.pkt_type = typ;
		h.byte_cnt = cnt;
		h.ecc      = ham_code({typ, cnt});
		h.parity   = ^{typ, cnt};
		return h;
	endfunction

	function automatic logic [MEM_AW-1:0] rand_base(input int lo, input int hi);
		int v;
		v = $urandom_range(hi, lo);
		return v[MEM_AW-1:0];
	endfunction

	task automatic new_payload(input int n);
		logic [31:0] rnd;
		for (int i = 0; i < 16; i++) begin
			rnd = $urandom;
			pay[i[3:0]] = rnd[7:0];
		end
		pay_len = n;
		crc_byte = crc_model(n);
	endtask

	// Header, payload words, then the CRC word; upper bytes are noise
	task automatic write_packet(input logic [MEM_AW-1:0] base, input hdr_t h);
		logic [MEM_AW-1:0] a;
		logic [31:0] rnd;
		a = base;
		mem[a] = h;
		for (int i = 0; i < pay_len; i++) begin
			a = a + 1'b1;
			rnd = $urandom;
			mem[a] = {rnd[31:8], pay[i[3:0]]};
		end
		a = a + 1'b1;
		rnd = $urandom;
		mem[a] = {rnd[31:8], crc_byte};
	endtask

	task automatic start_check(input logic [MEM_AW-1:0] base);
		axil_write(CSR_HDR_ADDR, {{(32 - MEM_AW){1'b0}}, base});
		axil_write(CSR_CTRL, 32'd1);
	endtask

	task automatic finish_check(input pkt_result_t exp);
		logic [31:0] rd;
		pkt_result_t got;
		int n;
		n = 0;
		while (!irq) begin
			n++;
			if (n > 100)
				report_timeout("irq_o after a start");
			@(negedge clk);
		end
		axil_read(CSR_STATUS, rd);
		got = {rd[1], rd[2], rd[3], rd[7:4], rd[11:8]};
		check_status_bit("status.done", rd[0], 1'b1);
		check_status_bit("status.busy", rd[16], 1'b0);
		check_result("status result", got, exp);
		// W1C on done drops the interrupt
		axil_write(CSR_STATUS, 32'd1);
		check_status_bit("irq_o", irq, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] rd;
		logic [31:0] rnd;
		logic [MEM_AW-1:0] addr_w;
		logic [MEM_AW-1:0] base_b;
		pkt_result_t exp_a;
		int b1;
		int b2;
		void'($urandom(11));
		n_checks = 0;
		reset    = 1'b1;
		axil_req = '0;
		mem_data = '0;
		fill_memory();
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Header address readback with an unmapped write and read
		rnd = $urandom;
		addr_w = rnd[MEM_AW-1:0];
		axil_write(CSR_HDR_ADDR, {{(32 - MEM_AW){1'b0}}, addr_w});
		axil_write(CSR_UNMAPPED, 32'hFFFF_FFFF);
		repeat (4) begin
			axil_read(CSR_HDR_ADDR, rd);
			check_rdata("hdr_addr readback", rd, {{(32 - MEM_AW){1'b0}}, addr_w});
		end
		axil_read(CSR_UNMAPPED, rd);
		check_rdata("unmapped read", rd, 32'd0);

		// Clean packets
		repeat (8) begin
			new_payload($urandom_range(15, 0));
			rnd = $urandom;
			hdr = make_header(pay_len[3:0], rnd[3:0]);
			pkt_base = rand_base(16, MEM_WORDS - 32);
			write_packet(pkt_base, hdr);
			exp_res = {1'b0, 1'b0, 1'b0, hdr.byte_cnt, hdr.pkt_type};
			start_check(pkt_base);
			finish_check(exp_res);
		end

		// One bit hit in a payload byte or in the stored CRC
		repeat (6) begin
			new_payload($urandom_range(15, 0));
			rnd = $urandom;
			hdr = make_header(pay_len[3:0], rnd[3:0]);
			if (pay_len != 0 && rnd[4]) begin
				b1 = $urandom_range(pay_len - 1, 0);
				pay[b1[3:0]] = pay[b1[3:0]] ^ (8'd1 << rnd[7:5]);
			end else begin
				crc_byte = crc_byte ^ (8'd1 << rnd[7:5]);
			end
			pkt_base = rand_base(16, MEM_WORDS - 32);
			write_packet(pkt_base, hdr);
			exp_res = {1'b0, 1'b0, crc_model(pay_len) != crc_byte, hdr.byte_cnt,
				hdr.pkt_type};
			start_check(pkt_base);
			finish_check(exp_res);
		end

		// Every single header bit from ecc[0] up to parity
		for (int b = 0; b < 13; b++) begin
			new_payload($urandom_range(15, 0));
			rnd = $urandom;
			hdr = make_header(pay_len[3:0], rnd[3:0]);
			bad = hdr ^ (32'd1 << b);
			pkt_base = rand_base(16, MEM_WORDS - 32);
			write_packet(pkt_base, bad);
			// Parity covers data bits only
			// code bit flip reads as uncorrectable, parity flip as clean
			exp_res = {(b >= 4) && (b <= 11), b < 4, 1'b0, hdr.byte_cnt, hdr.pkt_type};
			start_check(pkt_base);
			finish_check(exp_res);
		end

		// Two data bits give no repair and no CRC verdict
		repeat (4) begin
			new_payload($urandom_range(15, 0));
			rnd = $urandom;
			hdr = make_header(pay_len[3:0], rnd[3:0]);
			b1 = $urandom_range(7, 0);
			b2 = (b1 + $urandom_range(7, 1)) % 8;
			bad = hdr ^ (32'd1 << (b1 + 4)) ^ (32'd1 << (b2 + 4));
			pkt_base = rand_base(16, MEM_WORDS - 32);
			write_packet(pkt_base, bad);
			exp_res = {1'b0, 1'b1, 1'b0, bad.byte_cnt, bad.pkt_type};
			start_check(pkt_base);
			finish_check(exp_res);
		end

		// Second start while the long packet is still walking
		new_payload(15);
		rnd = $urandom;
		hdr = make_header(4'd15, rnd[3:0]);
		pkt_base = rand_base(16, 8000);
		write_packet(pkt_base, hdr);
		exp_a = {1'b0, 1'b0, 1'b0, hdr.byte_cnt, hdr.pkt_type};
		new_payload(2);
		hdr = make_header(4'd2, ~rnd[3:0]);
		base_b = rand_base(8192, MEM_WORDS - 32);
		write_packet(base_b, hdr);
		start_check(pkt_base);
		start_check(base_b);
		axil_read(CSR_STATUS, rd);
		check_status_bit("status.busy", rd[16], 1'b1);
		finish_check(exp_a);

		if (n_checks == 0) begin
			$display("No checks were run");
			stop_run();
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

// ==== sim.f ====
design/pkt_check_pkg.sv
design/crc8_byte.sv
design/hdr_ecc.sv
design/pkt_walker.sv
design/axil_csr.sv
design/pkt_check_top.sv
bench/tb_pkt_check_sva.sv
bench/tb_pkt_check.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_pkt_check -f sim.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
